// ==== vic_pkg.sv ====
`default_nettype none

package vic_pkg;

    // chip variant code, latched while the board reset is held
    typedef logic [1:0] chip_t;

    // cpu cycle within a raster line, 0 to 64 on the longest chip
    typedef logic [6:0] xcycle_t;

    // raster line within a frame, 0 to 311 on the pal parts
    typedef logic [8:0] raster_t;

    // ntsc, 65 cycles x 263 lines
    localparam chip_t chip_6567r8   = 2'd0;
    // pal, 63 cycles x 312 lines
    localparam chip_t chip_6569     = 2'd1;
    // early ntsc, 64 cycles x 262 lines
    localparam chip_t chip_6567r56a = 2'd2;
    // pal-n, 65 cycles x 312 lines
    localparam chip_t chip_6572     = 2'd3;

    // dots per cpu phase, the dot clock is 8x phi on every variant
    localparam int dots_per_phi = 8;

    // hsync width in phi cycles, counted from cycle 0 of the line
    localparam xcycle_t hsync_cycles = 7'd5;

    // vsync width in lines, counted from line 0 of the frame
    localparam raster_t vsync_lines = 9'd3;

    // cpu cycles in one raster line
    function automatic xcycle_t cycles_per_line(input chip_t c);
        case (c)
            chip_6567r8:   return 7'd65;
            chip_6569:     return 7'd63;
            chip_6567r56a: return 7'd64;
            // chip_6572 shares the ntsc line length
            default:       return 7'd65;
        endcase
    endfunction

    // raster lines in one frame
    function automatic raster_t lines_per_frame(input chip_t c);
        case (c)
            chip_6567r8:   return 9'd263;
            chip_6569:     return 9'd312;
            chip_6567r56a: return 9'd262;
            // chip_6572 keeps the pal line count
            default:       return 9'd312;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== vic_clockgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_clockgen #(
    // stretch counter width, 5 for simulation, about 21 for the real 150 ms
    parameter int RST_HOLD_BITS = 5
) (
    input  wire                 sys_clock,
    input  wire                 internal_rst,
    input  wire vic_pkg::chip_t chip_request,
    output logic                rst,
    output vic_pkg::chip_t      chip
);

    // increment constant sized to the counter
    localparam logic [RST_HOLD_BITS:0] cnt_one = 1;

    // msb set means the hold time has run out
    logic [RST_HOLD_BITS:0] stretch_cnt;
    // stretched reset, before synchronizing
    logic                   hold;
    // first synchronizer stage
    logic                   sync_ff;

    // hold stays up until the counter msb sets
    assign hold = ~stretch_cnt[RST_HOLD_BITS];

    // stretch counter
    // cleared while the board reset is up, then counts once per clock
    // and parks when the msb sets
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            stretch_cnt <= '0;
        end else if (hold) begin
            stretch_cnt <= stretch_cnt + cnt_one;
        end
    end

    // two flop synchronizer on the hold level
    // both stages are forced high by the board reset so rst follows it
    // at once, release takes two more clocks
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            sync_ff <= 1'b1;
            rst     <= 1'b1;
        end else begin
            sync_ff <= hold;
            rst     <= sync_ff;
        end
    end

    // chip latch
    // tracks the request only while the board reset is held, so the
    // line and frame limits never move under a running raster
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            chip <= chip_request;
        end
    end

    // once the board reset is gone the variant must not change,
    // the raster counter limits depend on it for the whole frame
    chip_stable_a : assert property (
        @(posedge sys_clock) !internal_rst |=> $stable(chip)
    );

endmodule

`default_nettype wire

// ==== dot_phase_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module dot_phase_gen #(
    // sys_clock cycles per dot
    parameter int DOT_DIV = 4
) (
    input  wire  sys_clock,
    input  wire  rst,
    output logic dot_strobe,
    output logic phi,
    output logic phi_strobe
);

    // one phi period in sys_clock cycles, 32 by default
    localparam int period = DOT_DIV * vic_pkg::dots_per_phi;
    localparam int cnt_w  = $clog2(period);

    localparam logic [cnt_w-1:0] cnt_one  = 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(period - 1);
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(period / 2);
    localparam logic [cnt_w-1:0] dot_div  = cnt_w'(DOT_DIV);
    localparam logic [cnt_w-1:0] dot_last = cnt_w'(DOT_DIV - 1);

    // position inside the phi period
    logic [cnt_w-1:0] cnt;

    // free running period counter, wraps at period - 1
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == cnt_last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + cnt_one;
        end
    end

    // registered decode of the counter
    // outputs lag the count by one clock, so the first dot strobe
    // lands DOT_DIV cycles after rst drops
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            dot_strobe <= 1'b0;
            phi        <= 1'b0;
            phi_strobe <= 1'b0;
        end else begin
            // one pulse per dot, stands in for the divided dot clock
            dot_strobe <= ((cnt % dot_div) == dot_last);
            // low for the first half of the period, high for the second
            phi        <= (cnt >= cnt_half);
            // end of the phi high half, closes the cpu cycle
            phi_strobe <= (cnt == cnt_last);
        end
    end

    // a cpu cycle always ends on a dot boundary
    phi_on_dot_a : assert property (
        @(posedge sys_clock) disable iff (rst) phi_strobe |-> dot_strobe
    );

endmodule

`default_nettype wire

// ==== raster_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module raster_counter (
    input  wire                   sys_clock,
    input  wire                   rst,
    input  wire                   phi_strobe,
    input  wire vic_pkg::chip_t   chip,
    output vic_pkg::xcycle_t      xcycle,
    output vic_pkg::raster_t      raster_line
);

    // last cycle of a line and last line of a frame for this chip
    vic_pkg::xcycle_t xcycle_last;
    vic_pkg::raster_t raster_last;

    // wrap points come from the latched variant
    assign xcycle_last = vic_pkg::cycles_per_line(chip) - 7'd1;
    assign raster_last = vic_pkg::lines_per_frame(chip) - 9'd1;

    // beam position in cpu cycles within the line
    // steps once per phi strobe, new value shows the clock after
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            xcycle <= '0;
        end else if (phi_strobe) begin
            if (xcycle == xcycle_last) begin
                xcycle <= '0;
            end else begin
                xcycle <= xcycle + 7'd1;
            end
        end
    end

    // raster line
    // advances only on the strobe that wraps the cycle count
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            raster_line <= '0;
        end else if (phi_strobe && (xcycle == xcycle_last)) begin
            if (raster_line == raster_last) begin
                raster_line <= '0;
            end else begin
                raster_line <= raster_line + 9'd1;
            end
        end
    end

    // position must stay inside the frame of the chip latched by
    // the clock generator
    xcycle_limit_a : assert property (
        @(posedge sys_clock) disable iff (rst)
        xcycle < vic_pkg::cycles_per_line(chip)
    );

    raster_limit_a : assert property (
        @(posedge sys_clock) disable iff (rst)
        raster_line < vic_pkg::lines_per_frame(chip)
    );

endmodule

`default_nettype wire

// ==== sync_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_gen (
    input  wire                   sys_clock,
    input  wire                   rst,
    input  wire                   phi_strobe,
    input  wire vic_pkg::xcycle_t xcycle,
    input  wire vic_pkg::raster_t raster_line,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  frame_start
);

    // high on the clock where the counters show a fresh position
    logic strobe_d;

    // phi strobe delayed to line up with the counter update
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            strobe_d <= 1'b0;
        end else begin
            strobe_d <= phi_strobe;
        end
    end

    // registered sync decode, one clock behind the beam position
    always_ff @(posedge sys_clock) begin
        if (rst) begin
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // start of every line
            hsync       <= (xcycle < vic_pkg::hsync_cycles);
            // top of every frame
            vsync       <= (raster_line < vic_pkg::vsync_lines);
            // wrap to 0,0 seen only right after a counter step,
            // so the reset position does not count as a new frame
            frame_start <= strobe_d && (xcycle == '0) && (raster_line == '0);
        end
    end

    // the frame pulse sits inside the vsync window it opens
    frame_in_vsync_a : assert property (
        @(posedge sys_clock) disable iff (rst) frame_start |-> vsync
    );

endmodule

`default_nettype wire

// ==== vic_timing_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vic_timing_top #(
    // reset stretch width, short for simulation
    parameter int RST_HOLD_BITS = 5,
    // sys_clock cycles per dot, the board clock stands for the 4x dot clock
    parameter int DOT_DIV       = 4
) (
    input  wire                   sys_clock,
    input  wire                   internal_rst,
    input  wire vic_pkg::chip_t   chip_request,
    output wire                   rst,
    output wire vic_pkg::chip_t   chip,
    output wire                   dot_strobe,
    output wire                   phi,
    output wire                   phi_strobe,
    output wire vic_pkg::xcycle_t xcycle,
    output wire vic_pkg::raster_t raster_line,
    output wire                   hsync,
    output wire                   vsync,
    output wire                   frame_start
);

    // reset stretch, synchronizer and chip latch
    vic_clockgen #(
        .RST_HOLD_BITS (RST_HOLD_BITS)
    ) clockgen0 (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .chip_request (chip_request),
        .rst          (rst),
        .chip         (chip)
    );

    // dot and cpu phase strobes, all in the sys_clock domain
    dot_phase_gen #(
        .DOT_DIV (DOT_DIV)
    ) dotgen0 (
        .sys_clock  (sys_clock),
        .rst        (rst),
        .dot_strobe (dot_strobe),
        .phi        (phi),
        .phi_strobe (phi_strobe)
    );

    // beam position, limits follow the latched chip
    raster_counter raster0 (
        .sys_clock   (sys_clock),
        .rst         (rst),
        .phi_strobe  (phi_strobe),
        .chip        (chip),
        .xcycle      (xcycle),
        .raster_line (raster_line)
    );

    // sync and frame start decode from the beam position
    sync_gen sync0 (
        .sys_clock   (sys_clock),
        .rst         (rst),
        .phi_strobe  (phi_strobe),
        .xcycle      (xcycle),
        .raster_line (raster_line),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start)
    );

endmodule

`default_nettype wire

// ==== tb_vic_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_vic_timing;

    // dut defaults, the reference model below uses the same values
    localparam int rst_hold_bits = 5;
    localparam int dot_div       = 4;
    localparam int phi_period    = dot_div * vic_pkg::dots_per_phi;
    // longest frame in sys_clock cycles, 65 cycles x 312 lines
    localparam int frame_cycles_max = 65 * 312 * phi_period;
    // frame test runs four frames, short tests and margin fill the rest
    localparam int timeout_cycles = 4 * frame_cycles_max + 404_160;
    // keeps a broken run from flooding the console
    localparam int max_error_lines = 40;

    logic             sys_clock;
    logic             internal_rst;
    vic_pkg::chip_t   chip_request;

    wire                   rst;
    wire vic_pkg::chip_t   chip;
    wire                   dot_strobe;
    wire                   phi;
    wire                   phi_strobe;
    wire vic_pkg::xcycle_t xcycle;
    wire vic_pkg::raster_t raster_line;
    wire                   hsync;
    wire                   vsync;
    wire                   frame_start;

    int cycle_count  = 0;
    int error_count  = 0;
    int error_lines  = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    vic_timing_top dut0 (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .chip_request (chip_request),
        .rst          (rst),
        .chip         (chip),
        .dot_strobe   (dot_strobe),
        .phi          (phi),
        .phi_strobe   (phi_strobe),
        .xcycle       (xcycle),
        .raster_line  (raster_line),
        .hsync        (hsync),
        .vsync        (vsync),
        .frame_start  (frame_start)
    );

    // 8 ns board clock
    initial begin
        sys_clock = 1'b0;
        forever #4 sys_clock = ~sys_clock;
    end

    // run limit, any wait on the dut that never ends lands here
    always @(posedge sys_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run stopped after %0d cycles waiting on the dut", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input int got, input int exp);
        error_count++;
        test_errors++;
        if (error_lines < max_error_lines) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end else if (error_lines == max_error_lines) begin
            $display("more errors follow, their lines are not shown");
        end
        error_lines++;
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        test_errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    // one line per test, then clear the per test count
    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // board reset for two cycles, request loaded into the chip latch meanwhile
    task automatic reapply_reset(input vic_pkg::chip_t c);
        @(negedge sys_clock);
        internal_rst = 1'b1;
        chip_request = c;
        repeat (2) @(negedge sys_clock);
        internal_rst = 1'b0;
    endtask

    // all derived outputs must sit low while rst is up
    task automatic check_quiet();
        if (dot_strobe !== 1'b0) report_mismatch("dot_strobe", int'(dot_strobe), 0);
        if (phi !== 1'b0) report_mismatch("phi", int'(phi), 0);
        if (phi_strobe !== 1'b0) report_mismatch("phi_strobe", int'(phi_strobe), 0);
        if (hsync !== 1'b0) report_mismatch("hsync", int'(hsync), 0);
        if (vsync !== 1'b0) report_mismatch("vsync", int'(vsync), 0);
        if (frame_start !== 1'b0) report_mismatch("frame_start", int'(frame_start), 0);
    endtask

    // count clocks until rst is seen low, returns on that falling edge
    task automatic wait_rst_release(output int held);
        held = 0;
        do begin
            @(negedge sys_clock);
            held++;
            if (rst) check_quiet();
        end while (rst);
    endtask

    // follow the beam for a number of lines, checking the line length
    // and the line step at each cycle wrap
    task automatic measure_lines(input int lines, input vic_pkg::chip_t c);
        int strobes;
        int done;
        int prev_x;
        int prev_line;
        int exp_line;
        strobes   = 0;
        done      = 0;
        prev_x    = int'(xcycle);
        prev_line = int'(raster_line);
        while (done < lines) begin
            @(negedge sys_clock);
            if (chip !== c) report_mismatch("chip", int'(chip), int'(c));
            // the strobe is counted on the clock before the new position shows
            if (phi_strobe) strobes++;
            if (int'(xcycle) == 0 && prev_x != 0) begin
                exp_line = (prev_line + 1) % int'(vic_pkg::lines_per_frame(c));
                if (strobes != int'(vic_pkg::cycles_per_line(c)))
                    report_mismatch("phi_strobe per line", strobes,
                                    int'(vic_pkg::cycles_per_line(c)));
                if (int'(raster_line) != exp_line)
                    report_mismatch("raster_line", int'(raster_line), exp_line);
                strobes = 0;
                done++;
            end else if (int'(raster_line) != prev_line) begin
                report_failure("raster_line moved without a cycle wrap");
            end
            prev_x    = int'(xcycle);
            prev_line = int'(raster_line);
        end
    endtask

    // 1. stretch is 2**bits clocks plus two synchronizer clocks
    task automatic test_reset_stretch();
        int held;
        int exp_held;
        exp_held = (1 << rst_hold_bits) + 2;
        reapply_reset(vic_pkg::chip_6569);
        wait_rst_release(held);
        if (held != exp_held) report_mismatch("rst hold cycles", held, exp_held);
        close_test("reset_stretch");
    endtask

    // 2. starts on the edge where rst was first seen low
    task automatic test_strobe_spacing();
        int since_dot;
        int since_phi;
        int phi_high;
        int n_phi;
        logic exp_phi;
        since_dot = 0;
        since_phi = 0;
        phi_high  = 0;
        n_phi     = 0;
        while (n_phi < 4) begin
            @(negedge sys_clock);
            since_dot++;
            since_phi++;
            // low for the first half of the period, high for the second
            exp_phi = (since_phi > phi_period / 2);
            if (phi !== exp_phi) report_mismatch("phi", int'(phi), int'(exp_phi));
            if (phi) phi_high++;
            if (dot_strobe) begin
                if (since_dot != dot_div) report_mismatch("dot_strobe spacing", since_dot, dot_div);
                since_dot = 0;
            end
            if (phi_strobe) begin
                n_phi++;
                if (since_phi != phi_period)
                    report_mismatch("phi_strobe spacing", since_phi, phi_period);
                if (phi_high != phi_period / 2)
                    report_mismatch("phi high cycles", phi_high, phi_period / 2);
                if (!dot_strobe) report_failure("phi_strobe came without dot_strobe");
                since_phi = 0;
                phi_high  = 0;
            end
        end
        close_test("strobe_spacing");
    endtask

    // 3. two lines per variant, variants in shuffled order
    task automatic test_line_length(input vic_pkg::chip_t order[4]);
        int held;
        for (int i = 0; i < 4; i++) begin
            reapply_reset(order[i]);
            wait_rst_release(held);
            measure_lines(2, order[i]);
        end
        close_test("line_length");
    endtask

    // 4. two frames each, beam position followed by a model stepped on phi_strobe
    task automatic test_frame_sync(input vic_pkg::chip_t c);
        int held;
        int strobes;
        int frames;
        int exp_strobes;
        int cpl;
        int lpf;
        int mx;
        int ml;
        logic step;
        logic exp_h;
        logic exp_v;
        cpl         = int'(vic_pkg::cycles_per_line(c));
        lpf         = int'(vic_pkg::lines_per_frame(c));
        exp_strobes = cpl * lpf;
        reapply_reset(c);
        wait_rst_release(held);
        strobes = 0;
        frames  = 0;
        mx      = 0;
        ml      = 0;
        step    = 1'b0;
        while (frames < 2) begin
            @(negedge sys_clock);
            // sync decode lags the beam position by one clock
            exp_h = (mx < int'(vic_pkg::hsync_cycles));
            exp_v = (ml < int'(vic_pkg::vsync_lines));
            // position moves on the clock after a strobe
            if (step) begin
                if (mx == cpl - 1) begin
                    mx = 0;
                    ml = (ml + 1) % lpf;
                end else begin
                    mx++;
                end
            end
            if (int'(xcycle) != mx) report_mismatch("xcycle", int'(xcycle), mx);
            if (int'(raster_line) != ml) report_mismatch("raster_line", int'(raster_line), ml);
            if (hsync !== exp_h) report_mismatch("hsync", int'(hsync), int'(exp_h));
            if (vsync !== exp_v) report_mismatch("vsync", int'(vsync), int'(exp_v));
            if (frame_start) begin
                frames++;
                if (strobes != exp_strobes)
                    report_mismatch("phi_strobe per frame", strobes, exp_strobes);
                strobes = 0;
            end
            if (phi_strobe) strobes++;
            step = phi_strobe;
        end
        close_test(c == vic_pkg::chip_6569 ? "frame_sync_pal" : "frame_sync_ntsc");
    endtask

    // 5. request change while running is ignored until the next reset
    task automatic test_chip_latch();
        int held;
        reapply_reset(vic_pkg::chip_6569);
        wait_rst_release(held);
        @(negedge sys_clock);
        chip_request = vic_pkg::chip_6567r8;
        measure_lines(1, vic_pkg::chip_6569);
        reapply_reset(vic_pkg::chip_6567r8);
        wait_rst_release(held);
        if (chip !== vic_pkg::chip_6567r8)
            report_mismatch("chip", int'(chip), int'(vic_pkg::chip_6567r8));
        measure_lines(1, vic_pkg::chip_6567r8);
        close_test("chip_latch");
    endtask

    initial begin
        vic_pkg::chip_t order[4];
        vic_pkg::chip_t tmp;
        int j;
        internal_rst = 1'b1;
        chip_request = vic_pkg::chip_6567r8;
        void'($urandom(32'h14896697));
        order = '{vic_pkg::chip_6567r8, vic_pkg::chip_6569,
                  vic_pkg::chip_6567r56a, vic_pkg::chip_6572};
        // shuffle of the variant order
        for (int i = 3; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end

        test_reset_stretch();
        // spacing is measured straight from the release above
        test_strobe_spacing();
        test_line_length(order);
        test_frame_sync(vic_pkg::chip_6569);
        test_frame_sync(vic_pkg::chip_6567r8);
        test_chip_latch();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
vic_pkg.sv
vic_clockgen.sv
dot_phase_gen.sv
raster_counter.sv
sync_gen.sv
vic_timing_top.sv
tb_vic_timing.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and pass only when the testbench reports a pass
verilator --binary --timing --assert --top-module tb_vic_timing -o tb_sim -f tb.f \
    && out="$(./obj_dir/tb_sim 2>&1 || true)" \
    && printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -q "Verification passed" \
    && exit 0 \
    || exit 1
